// ==== Makefile ====
TOP := mem_stage_tb
OBJ := obj_dir

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -Mdir $(OBJ) -f src.f

run: build
	./$(OBJ)/V$(TOP)

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f src.f

clean:
	rm -rf $(OBJ)

// ==== sim/mem_stage_tb.sv ====
// Only words stored earlier in the run are ever loaded, since RAM contents have no reset value
module mem_stage_tb;

  localparam int RAM_WORDS = 512;
  localparam int IDX_W     = $clog2(RAM_WORDS);
  localparam int TIMEOUT   = 20;

  logic                      i_clk;
  logic                      i_rst;
  logic                      i_valid;
  lsu_types_pkg::mem_addr_t  i_addr;
  lsu_types_pkg::xlen_word_t i_store_data;
  lsu_types_pkg::xlen_word_t i_alu_result;
  lsu_types_pkg::xlen_word_t i_csr_rdata;
  mem_op_pkg::mem_op_t       i_mem_op;
  logic                      i_mem_to_reg;
  logic                      i_wr_en;
  logic                      i_rd_en;
  logic                      i_sel_csr;
  logic                      o_wb_valid;
  lsu_types_pkg::xlen_word_t o_wb_data;
  logic                      o_store_fault;

  // Byte image of the RAM and the expected result of the request being driven
  logic [7:0]                model_mem [RAM_WORDS*8];
  lsu_types_pkg::xlen_word_t exp_data;
  logic                      exp_fault;
  logic                      chk_valid;
  lsu_types_pkg::xlen_word_t chk_data;
  logic                      chk_fault;

  mem_stage_top #(
    .RAM_WORDS (RAM_WORDS)
  ) u_dut (
    .i_clk         (i_clk),
    .i_rst         (i_rst),
    .i_valid       (i_valid),
    .i_addr        (i_addr),
    .i_store_data  (i_store_data),
    .i_alu_result  (i_alu_result),
    .i_csr_rdata   (i_csr_rdata),
    .i_mem_op      (i_mem_op),
    .i_mem_to_reg  (i_mem_to_reg),
    .i_wr_en       (i_wr_en),
    .i_rd_en       (i_rd_en),
    .i_sel_csr     (i_sel_csr),
    .o_wb_valid    (o_wb_valid),
    .o_wb_data     (o_wb_data),
    .o_store_fault (o_store_fault)
  );

  initial begin
    i_clk = 1'b0;
    forever #10 i_clk = ~i_clk;
  end

  task automatic abort_run(input string line);
    $display("%s", line);
    $display("Simulation failed");
    $fatal(1, "run aborted");
  endtask

  // ##################################################
  // Reference model
  // ##################################################

  function automatic int size_of(input mem_op_pkg::mem_op_t op);
    case (op)
      mem_op_pkg::MEM_LB, mem_op_pkg::MEM_LBU: return 1;
      mem_op_pkg::MEM_LH, mem_op_pkg::MEM_LHU: return 2;
      mem_op_pkg::MEM_LW, mem_op_pkg::MEM_LWU: return 4;
      mem_op_pkg::MEM_LD:                      return 8;
      default:                                 return 0;
    endcase
  endfunction

  function automatic int byte_slot(input lsu_types_pkg::mem_addr_t addr, input int lane);
    return int'(addr[3 +: IDX_W]) * 8 + lane;
  endfunction

  function automatic lsu_types_pkg::xlen_word_t rand_word();
    return {$urandom, $urandom};
  endfunction

  // Bytes past the end of the word read as zero; even codes are the signed loads
  function automatic lsu_types_pkg::xlen_word_t model_load(input mem_op_pkg::mem_op_t op,
                                                           input lsu_types_pkg::mem_addr_t addr);
    lsu_types_pkg::xlen_word_t value;
    int                        off;
    int                        n;
    value = '0;
    off   = int'(addr[2:0]);
    n     = size_of(op);
    for (int i = 0; i < n; i++) begin
      if (off + i < 8) begin
        value[8*i +: 8] = model_mem[byte_slot(addr, off + i)];
      end
    end
    if (n > 0 && n < 8 && op[0] == 1'b0 && value[8*n-1]) begin
      for (int i = n; i < 8; i++) begin
        value[8*i +: 8] = 8'hff;
      end
    end
    return value;
  endfunction

  // ##################################################
  // Request drivers
  // ##################################################

  task automatic send(input mem_op_pkg::mem_op_t op, input lsu_types_pkg::mem_addr_t addr,
                      input lsu_types_pkg::xlen_word_t sdata, input logic m2r,
                      input logic wr, input logic rd, input logic sel);
    int off;
    int n;
    i_valid      = 1'b1;
    i_addr       = addr;
    i_store_data = sdata;
    i_alu_result = rand_word();
    i_csr_rdata  = rand_word();
    i_mem_op     = op;
    i_mem_to_reg = m2r;
    i_wr_en      = wr;
    i_rd_en      = rd;
    i_sel_csr    = sel;
    if (m2r) begin
      exp_data = rd ? model_load(op, addr) : '0;
    end else if (sel) begin
      exp_data = i_csr_rdata;
    end else begin
      exp_data = i_alu_result;
    end
    // The load above sees memory from before this request's own store
    off       = int'(addr[2:0]);
    n         = size_of(op);
    exp_fault = 1'b0;
    if (wr && n > 0) begin
      if (off % n != 0) begin
        exp_fault = 1'b1;
      end else begin
        for (int i = 0; i < n; i++) begin
          model_mem[byte_slot(addr, off + i)] = sdata[8*i +: 8];
        end
      end
    end
    @(posedge i_clk);
    #2;
  endtask

  task automatic store_req(input mem_op_pkg::mem_op_t op, input lsu_types_pkg::mem_addr_t addr,
                           input lsu_types_pkg::xlen_word_t sdata);
    send(op, addr, sdata, 1'b0, 1'b1, 1'b0, 1'b0);
  endtask

  task automatic load_req(input mem_op_pkg::mem_op_t op, input lsu_types_pkg::mem_addr_t addr);
    send(op, addr, rand_word(), 1'b1, 1'b0, 1'b1, 1'b0);
  endtask

  task automatic go_idle();
    i_valid      = 1'b0;
    i_mem_op     = mem_op_pkg::MEM_NONE;
    i_mem_to_reg = 1'b0;
    i_wr_en      = 1'b0;
    i_rd_en      = 1'b0;
    i_sel_csr    = 1'b0;
  endtask

  // Waits for the last strobe, then one more edge so its checks run
  task automatic drain();
    int cycles;
    go_idle();
    cycles = 0;
    while (!o_wb_valid) begin
      if (cycles >= TIMEOUT) begin
        abort_run("Timeout: no writeback strobe followed the last request");
      end
      @(posedge i_clk);
      #2;
      cycles++;
    end
    @(posedge i_clk);
    #2;
  endtask

  // ##################################################
  // Checks
  // ##################################################

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      chk_valid <= 1'b0;
    end else begin
      chk_valid <= i_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    chk_data  <= exp_data;
    chk_fault <= i_valid && exp_fault;
  end

  assert property (@(posedge i_clk) disable iff (i_rst) o_wb_valid == chk_valid)
    else abort_run($sformatf("** Error at %0t: o_wb_valid is %b, expected %b",
                             $time, $sampled(o_wb_valid), $sampled(chk_valid)));

  assert property (@(posedge i_clk) disable iff (i_rst) chk_valid |-> o_wb_data == chk_data)
    else abort_run($sformatf("** Error at %0t: o_wb_data is %h, expected %h",
                             $time, $sampled(o_wb_data), $sampled(chk_data)));

  assert property (@(posedge i_clk) disable iff (i_rst) o_store_fault == chk_fault)
    else abort_run($sformatf("** Error at %0t: o_store_fault is %b, expected %b",
                             $time, $sampled(o_store_fault), $sampled(chk_fault)));

  // ##################################################
  // Stimulus
  // ##################################################

  initial begin
    lsu_types_pkg::mem_addr_t addr;
    mem_op_pkg::mem_op_t      op;
    int                       kind;
    void'($urandom(32'h23aa_9456));
    i_rst        = 1'b1;
    i_addr       = '0;
    i_store_data = '0;
    i_alu_result = '0;
    i_csr_rdata  = '0;
    go_idle();
    repeat (10) @(posedge i_clk);
    #2;
    i_rst = 1'b0;

    // Every load code at every offset of one known word
    store_req(mem_op_pkg::MEM_LD, 64'h200, 64'h8172_e354_c536_a718);
    for (int c = 0; c < 7; c++) begin
      for (int off = 0; off < 8; off++) begin
        load_req(mem_op_pkg::mem_op_t'(c), 64'h200 + lsu_types_pkg::mem_addr_t'(off));
      end
    end
    drain();

    // Aligned partial stores, each read back as a whole word
    store_req(mem_op_pkg::MEM_LD, 64'h208, rand_word());
    for (int s = 0; s < 3; s++) begin
      for (int off = 0; off < 8; off += (1 << s)) begin
        store_req(mem_op_pkg::mem_op_t'(2 * s), 64'h208 + lsu_types_pkg::mem_addr_t'(off),
                  rand_word());
        load_req(mem_op_pkg::MEM_LD, 64'h208);
      end
    end
    drain();

    // Misaligned half, word and double stores
    store_req(mem_op_pkg::MEM_LD, 64'h210, rand_word());
    for (int s = 1; s < 4; s++) begin
      for (int off = 1; off < 8; off++) begin
        if (off % (1 << s) != 0) begin
          store_req(mem_op_pkg::mem_op_t'(2 * s), 64'h210 + lsu_types_pkg::mem_addr_t'(off),
                    rand_word());
          load_req(mem_op_pkg::MEM_LD, 64'h210);
        end
      end
    end
    drain();

    // Writeback source select and MEM_NONE with write enable
    for (int k = 0; k < 16; k++) begin
      send(mem_op_pkg::mem_op_t'($urandom_range(7, 0)), 64'h218, rand_word(),
           1'b0, 1'b0, 1'b0, k % 2 == 1);
    end
    store_req(mem_op_pkg::MEM_LD, 64'h218, rand_word());
    send(mem_op_pkg::MEM_NONE, 64'h218, rand_word(), 1'b0, 1'b1, 1'b0, 1'b0);
    send(mem_op_pkg::MEM_NONE, 64'h21c, rand_word(), 1'b0, 1'b1, 1'b0, 1'b1);
    load_req(mem_op_pkg::MEM_LD, 64'h218);
    drain();

    // Random traffic in an 8-word window, upper address bits wrap
    for (int w = 0; w < 8; w++) begin
      store_req(mem_op_pkg::MEM_LD, 64'h300 + lsu_types_pkg::mem_addr_t'(8 * w), rand_word());
    end
    for (int k = 0; k < 400; k++) begin
      kind        = int'($urandom_range(3, 0));
      addr        = rand_word();
      addr[11:0]  = 12'h300 + 12'($urandom_range(63, 0));
      op          = mem_op_pkg::mem_op_t'($urandom_range(6, 0));
      case (kind)
        0: load_req(op, addr);
        1: store_req(op, addr, rand_word());
        2: begin
          store_req(op, addr, rand_word());
          load_req(mem_op_pkg::mem_op_t'($urandom_range(6, 0)),
                   {addr[63:3], 3'($urandom_range(7, 0))});
        end
        default: begin
          send(mem_op_pkg::mem_op_t'($urandom_range(7, 0)), addr, rand_word(),
               $urandom % 2 == 1, $urandom % 2 == 1, $urandom % 2 == 1, $urandom % 2 == 1);
        end
      endcase
    end
    drain();

    $display("Simulation passed");
    $finish;
  end

endmodule

// ==== source/data_ram.sv ====
// RAM_WORDS must be a power of two, at least 2; contents power up undefined and are never reset
module data_ram #(
  parameter int RAM_WORDS = 512
) (
  input  logic                              i_clk,
  input  logic                              i_en,
  input  logic                              i_we,
  input  logic [$clog2(RAM_WORDS)-1:0]      i_index,
  input  lsu_types_pkg::byte_mask_t         i_wmask,
  input  lsu_types_pkg::xlen_word_t         i_wdata,
  output lsu_types_pkg::xlen_word_t         o_rdata
);

  lsu_types_pkg::xlen_word_t mem [RAM_WORDS];

  // ##################################################
  // Write port
  // ##################################################

  // Only enabled lanes change, the others keep their bytes
  always_ff @(posedge i_clk) begin
    if (i_en && i_we) begin
      for (int lane = 0; lane < 8; lane++) begin
        if (i_wmask[lane]) begin
          mem[i_index][8*lane +: 8] <= i_wdata[8*lane +: 8];
        end
      end
    end
  end

  // ##################################################
  // Read port
  // ##################################################

  // Read returns the contents from before this edge's write
  always_ff @(posedge i_clk) begin
    if (i_en) begin
      o_rdata <= mem[i_index];
    end
  end

endmodule

// ==== source/load_align.sv ====
// Purely combinational; misaligned loads return the shifted word with zeros above, never a fault
module load_align (
  input  mem_op_pkg::mem_op_t         i_mem_op,
  input  lsu_types_pkg::lane_offset_t i_offset,
  input  lsu_types_pkg::xlen_word_t   i_rdata,
  output lsu_types_pkg::xlen_word_t   o_load_value
);

  lsu_types_pkg::xlen_word_t shifted;

  // ##################################################
  // Lane shift
  // ##################################################

  // Addressed byte moves to lane 0, upper lanes fill with zeros
  assign shifted = i_rdata >> {i_offset, 3'b000};

  // ##################################################
  // Extension
  // ##################################################

  always_comb begin
    case (i_mem_op)
      mem_op_pkg::MEM_LB: begin
        o_load_value = {{56{shifted[7]}}, shifted[7:0]};
      end
      mem_op_pkg::MEM_LBU: begin
        o_load_value = {56'd0, shifted[7:0]};
      end
      mem_op_pkg::MEM_LH: begin
        o_load_value = {{48{shifted[15]}}, shifted[15:0]};
      end
      mem_op_pkg::MEM_LHU: begin
        o_load_value = {48'd0, shifted[15:0]};
      end
      mem_op_pkg::MEM_LW: begin
        o_load_value = {{32{shifted[31]}}, shifted[31:0]};
      end
      mem_op_pkg::MEM_LWU: begin
        o_load_value = {32'd0, shifted[31:0]};
      end
      mem_op_pkg::MEM_LD: begin
        o_load_value = shifted;
      end
      // MEM_NONE reads nothing useful
      default: begin
        o_load_value = '0;
      end
    endcase
  end

endmodule

// ==== source/lsu.sv ====
// One request per cycle, no back-pressure; addresses wrap modulo RAM_WORDS, a power of two
module lsu #(
  parameter int RAM_WORDS = 512
) (
  input  logic                            i_clk,
  input  logic                            i_rst,
  input  logic                            i_valid,
  input  lsu_types_pkg::mem_addr_t        i_addr,
  input  lsu_types_pkg::xlen_word_t       i_store_data,
  input  lsu_types_pkg::xlen_word_t       i_alu_result,
  input  lsu_types_pkg::xlen_word_t       i_csr_rdata,
  input  mem_op_pkg::mem_op_t             i_mem_op,
  input  logic                            i_mem_to_reg,
  input  logic                            i_wr_en,
  input  logic                            i_rd_en,
  input  logic                            i_sel_csr,
  input  lsu_types_pkg::xlen_word_t       i_ram_rdata,
  output logic                            o_ram_en,
  output logic                            o_ram_we,
  output logic [$clog2(RAM_WORDS)-1:0]    o_ram_index,
  output lsu_types_pkg::byte_mask_t       o_ram_wmask,
  output lsu_types_pkg::xlen_word_t       o_ram_wdata,
  output logic                            o_wb_valid,
  output lsu_types_pkg::xlen_word_t       o_wb_data,
  output logic                            o_store_fault
);

  localparam int IDX_W = $clog2(RAM_WORDS);

  lsu_types_pkg::lane_offset_t offset;
  logic                        st_misaligned;
  logic                        store_go;
  lsu_types_pkg::xlen_word_t   load_value;

  // Request fields held for the writeback cycle
  lsu_types_pkg::lane_offset_t offset_q;
  mem_op_pkg::mem_op_t         mem_op_q;
  logic                        mem_to_reg_q;
  logic                        rd_en_q;
  logic                        sel_csr_q;
  lsu_types_pkg::xlen_word_t   alu_q;
  lsu_types_pkg::xlen_word_t   csr_q;

  assign offset = i_addr[2:0];

  // ##################################################
  // RAM request
  // ##################################################

  store_align u_store_align (
    .i_mem_op     (i_mem_op),
    .i_offset     (offset),
    .i_store_data (i_store_data),
    .o_wmask      (o_ram_wmask),
    .o_wdata      (o_ram_wdata),
    .o_misaligned (st_misaligned)
  );

  assign store_go    = i_valid && i_wr_en && (i_mem_op != mem_op_pkg::MEM_NONE);
  assign o_ram_en    = (i_valid && i_rd_en) || store_go;
  assign o_ram_we    = store_go && !st_misaligned;
  assign o_ram_index = i_addr[3 +: IDX_W];

  // ##################################################
  // Request pipeline
  // ##################################################

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_wb_valid    <= 1'b0;
      o_store_fault <= 1'b0;
    end else begin
      o_wb_valid    <= i_valid;
      o_store_fault <= store_go && st_misaligned;
    end
  end

  always_ff @(posedge i_clk) begin
    offset_q     <= offset;
    mem_op_q     <= i_mem_op;
    mem_to_reg_q <= i_mem_to_reg;
    rd_en_q      <= i_rd_en;
    sel_csr_q    <= i_sel_csr;
    alu_q        <= i_alu_result;
    csr_q        <= i_csr_rdata;
  end

  // ##################################################
  // Writeback
  // ##################################################

  load_align u_load_align (
    .i_mem_op     (mem_op_q),
    .i_offset     (offset_q),
    .i_rdata      (i_ram_rdata),
    .o_load_value (load_value)
  );

  // Without a read the memory path gives zero, as the execute stage expects
  always_comb begin
    if (mem_to_reg_q) begin
      o_wb_data = rd_en_q ? load_value : '0;
    end else if (sel_csr_q) begin
      o_wb_data = csr_q;
    end else begin
      o_wb_data = alu_q;
    end
  end

  assert property (@(posedge i_clk) disable iff (i_rst)
    o_ram_we |-> $countones(o_ram_wmask) == int'(mem_op_pkg::access_bytes(i_mem_op)))
    else $error("lsu: RAM write mask %b does not match the access size", o_ram_wmask);

  assert property (@(posedge i_clk) disable iff (i_rst)
    o_ram_we |-> (o_ram_wmask & ((8'd1 << offset) - 8'd1)) == '0)
    else $error("lsu: RAM write enables a lane below offset %0d", offset);

endmodule

// ==== source/lsu_types_pkg.sv ====
// Word, mask and address widths are fixed for a 64-bit datapath with 8 byte lanes per word
package lsu_types_pkg;

  // ##################################################
  // Data path widths
  // ##################################################

  // One register-file or memory word
  typedef logic [63:0] xlen_word_t;

  // One write enable per byte lane of a word
  typedef logic [7:0] byte_mask_t;

  // Byte position of an access inside its word
  typedef logic [2:0] lane_offset_t;

  // ##################################################
  // Addressing
  // ##################################################

  // Full byte address as produced by the execute stage
  typedef logic [63:0] mem_addr_t;

endpackage

// ==== source/mem_op_pkg.sv ====
// Stores reuse the signed load codes for their size; MEM_NONE marks a request without memory access
package mem_op_pkg;

  // ##################################################
  // Operation codes
  // ##################################################

  typedef logic [2:0] mem_op_t;

  localparam mem_op_t MEM_LB   = 3'd0;
  localparam mem_op_t MEM_LBU  = 3'd1;
  localparam mem_op_t MEM_LH   = 3'd2;
  localparam mem_op_t MEM_LHU  = 3'd3;
  localparam mem_op_t MEM_LW   = 3'd4;
  localparam mem_op_t MEM_LWU  = 3'd5;
  localparam mem_op_t MEM_LD   = 3'd6;
  localparam mem_op_t MEM_NONE = 3'd7;

  // ##################################################
  // Access size
  // ##################################################

  // Number of bytes touched by an operation, zero for MEM_NONE
  function automatic logic [3:0] access_bytes(input mem_op_t op);
    logic [3:0] nbytes;
    case (op)
      MEM_LB, MEM_LBU: nbytes = 4'd1;
      MEM_LH, MEM_LHU: nbytes = 4'd2;
      MEM_LW, MEM_LWU: nbytes = 4'd4;
      MEM_LD:          nbytes = 4'd8;
      default:         nbytes = 4'd0;
    endcase
    return nbytes;
  endfunction

endpackage

// ==== source/mem_stage_top.sv ====
// Writeback follows every request by exactly one cycle; RAM_WORDS must be a power of two
module mem_stage_top #(
  parameter int RAM_WORDS = 512
) (
  input  logic                      i_clk,
  input  logic                      i_rst,
  input  logic                      i_valid,
  input  lsu_types_pkg::mem_addr_t  i_addr,
  input  lsu_types_pkg::xlen_word_t i_store_data,
  input  lsu_types_pkg::xlen_word_t i_alu_result,
  input  lsu_types_pkg::xlen_word_t i_csr_rdata,
  input  mem_op_pkg::mem_op_t       i_mem_op,
  input  logic                      i_mem_to_reg,
  input  logic                      i_wr_en,
  input  logic                      i_rd_en,
  input  logic                      i_sel_csr,
  output logic                      o_wb_valid,
  output lsu_types_pkg::xlen_word_t o_wb_data,
  output logic                      o_store_fault
);

  logic                        ram_en;
  logic                        ram_we;
  logic [$clog2(RAM_WORDS)-1:0] ram_index;
  lsu_types_pkg::byte_mask_t   ram_wmask;
  lsu_types_pkg::xlen_word_t   ram_wdata;
  lsu_types_pkg::xlen_word_t   ram_rdata;

  lsu #(
    .RAM_WORDS (RAM_WORDS)
  ) u_lsu (
    .i_clk         (i_clk),
    .i_rst         (i_rst),
    .i_valid       (i_valid),
    .i_addr        (i_addr),
    .i_store_data  (i_store_data),
    .i_alu_result  (i_alu_result),
    .i_csr_rdata   (i_csr_rdata),
    .i_mem_op      (i_mem_op),
    .i_mem_to_reg  (i_mem_to_reg),
    .i_wr_en       (i_wr_en),
    .i_rd_en       (i_rd_en),
    .i_sel_csr     (i_sel_csr),
    .i_ram_rdata   (ram_rdata),
    .o_ram_en      (ram_en),
    .o_ram_we      (ram_we),
    .o_ram_index   (ram_index),
    .o_ram_wmask   (ram_wmask),
    .o_ram_wdata   (ram_wdata),
    .o_wb_valid    (o_wb_valid),
    .o_wb_data     (o_wb_data),
    .o_store_fault (o_store_fault)
  );

  data_ram #(
    .RAM_WORDS (RAM_WORDS)
  ) u_ram (
    .i_clk   (i_clk),
    .i_en    (ram_en),
    .i_we    (ram_we),
    .i_index (ram_index),
    .i_wmask (ram_wmask),
    .i_wdata (ram_wdata),
    .o_rdata (ram_rdata)
  );

endmodule

// ==== source/store_align.sv ====
// Purely combinational; a store whose offset is not a multiple of its size gets an empty mask
module store_align (
  input  mem_op_pkg::mem_op_t       i_mem_op,
  input  lsu_types_pkg::lane_offset_t i_offset,
  input  lsu_types_pkg::xlen_word_t   i_store_data,
  output lsu_types_pkg::byte_mask_t   o_wmask,
  output lsu_types_pkg::xlen_word_t   o_wdata,
  output logic                        o_misaligned
);

  logic [3:0]                size_bytes;
  lsu_types_pkg::byte_mask_t base_mask;
  logic                      offset_bad;

  assign size_bytes = mem_op_pkg::access_bytes(i_mem_op);

  // ##################################################
  // Lane mask
  // ##################################################

  // Mask for an access at lane 0 before it moves up to the offset lane
  always_comb begin
    case (size_bytes)
      4'd1:    base_mask = 8'b0000_0001;
      4'd2:    base_mask = 8'b0000_0011;
      4'd4:    base_mask = 8'b0000_1111;
      4'd8:    base_mask = 8'b1111_1111;
      default: base_mask = 8'b0000_0000;
    endcase
  end

  // The low offset bits covered by the size must all be zero
  always_comb begin
    case (size_bytes)
      4'd2:    offset_bad = i_offset[0];
      4'd4:    offset_bad = |i_offset[1:0];
      4'd8:    offset_bad = |i_offset;
      default: offset_bad = 1'b0;
    endcase
  end

  assign o_misaligned = offset_bad;
  assign o_wmask      = offset_bad ? '0 : (base_mask << i_offset);

  // ##################################################
  // Write data
  // ##################################################

  // Low bytes of the store data land in the lane given by the offset
  assign o_wdata = i_store_data << {i_offset, 3'b000};

endmodule

// ==== src.f ====
source/lsu_types_pkg.sv
source/mem_op_pkg.sv
source/store_align.sv
source/load_align.sv
source/data_ram.sv
source/lsu.sv
source/mem_stage_top.sv
sim/mem_stage_tb.sv
